/* lane_macros.svh */
// Lane configuration macros
// Element width, register count, maximum vector length, queue depth

`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

// Width of one element in bits
`define LANE_ELEM_W 32

// Number of architectural vector registers
`define LANE_NR_VREGS 8

// Elements per vector register
`define LANE_VLMAX 4

// Operand and command queue depth
// One instruction never holds more than VLMAX elements in flight
`define LANE_QUEUE_DEPTH `LANE_VLMAX

`endif

/* lane_cfg_pkg.sv */
// Data-shape types of the lane
// Elements, register and element indices, vector length, operand pairs

`default_nettype none

`include "lane_macros.svh"

package lane_cfg_pkg;

  // One vector element
  typedef logic [`LANE_ELEM_W-1:0] elem_t;

  // Register number and element index within a register
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_idx_t;
  typedef logic [$clog2(`LANE_VLMAX)-1:0]    elem_idx_t;

  // Vector length, 1 to VLMAX
  typedef logic [$clog2(`LANE_VLMAX+1)-1:0] vl_t;

  // Element address in the register file
  typedef struct packed {
    vreg_idx_t vreg;
    elem_idx_t elem;
  } vrf_addr_t;

  // Both source elements of one element operation
  typedef struct packed {
    elem_t src1;
    elem_t src2;
  } operand_pair_t;

endpackage

`default_nettype wire

/* lane_insn_pkg.sv */
// Instruction-level types of the lane
// Opcodes, instruction request, ALU micro-operation, store beat

`default_nettype none

package lane_insn_pkg;

  // Supported vector operations
  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VMVX   = 3'd5,
    VSTORE = 3'd6
  } opcode_e;

  //////////////////////////////////////////////////
  // Instruction port
  //////////////////////////////////////////////////

  typedef struct packed {
    opcode_e                  op;
    lane_cfg_pkg::vreg_idx_t  vd;
    lane_cfg_pkg::vreg_idx_t  vs1;
    // Also the source register of a store
    lane_cfg_pkg::vreg_idx_t  vs2;
    lane_cfg_pkg::vl_t        vl;
    // Broadcast value for VMVX
    lane_cfg_pkg::elem_t      scalar;
  } lane_req_t;

  //////////////////////////////////////////////////
  // Sequencer to ALU
  //////////////////////////////////////////////////

  // One element operation
  typedef struct packed {
    opcode_e                  op;
    lane_cfg_pkg::vrf_addr_t  dst;
    logic                     last;
    lane_cfg_pkg::elem_t      scalar;
  } alu_uop_t;

  // Store stream beat
  typedef struct packed {
    lane_cfg_pkg::elem_t      data;
    logic                     last;
  } store_beat_t;

endpackage

`default_nettype wire

/* stream_fifo.sv */
// Circular buffer queue for any payload type
// Push without back-pressure, head with valid, pop at the edge

`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  payload_t  data_i,
  output payload_t  data_o,
  output logic      valid_o,
  input  logic      pop_i
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  payload_t           mem_q [DEPTH];
  logic [PtrW-1:0]    rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0]    cnt_q;
  logic               do_pop;

  assign valid_o = (cnt_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count changes only when exactly one side moves
      if (push_i && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && do_pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* vector_regfile.sv */
// Vector register file
// Two registered read ports and one write port

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module vector_regfile (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Read ports
  input  logic                         rd_en_i,
  input  lane_cfg_pkg::vrf_addr_t      rd_addr_a_i,
  input  lane_cfg_pkg::vrf_addr_t      rd_addr_b_i,
  output lane_cfg_pkg::operand_pair_t  rd_data_o,
  output logic                         rd_valid_o,
  // Write port
  input  logic                         wr_en_i,
  input  lane_cfg_pkg::vrf_addr_t      wr_addr_i,
  input  lane_cfg_pkg::elem_t          wr_data_i
);

  lane_cfg_pkg::elem_t          mem_q [`LANE_NR_VREGS][`LANE_VLMAX];
  lane_cfg_pkg::operand_pair_t  rd_data_q;
  logic                         rd_valid_q;

  // Storage, cleared on reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < `LANE_NR_VREGS; r++) begin
        for (int e = 0; e < `LANE_VLMAX; e++) begin
          mem_q[r][e] <= '0;
        end
      end
    end else if (wr_en_i) begin
      mem_q[wr_addr_i.vreg][wr_addr_i.elem] <= wr_data_i;
    end
  end

  // Read data, one cycle latency, returns the value before a same-edge write
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_q.src1 <= mem_q[rd_addr_a_i.vreg][rd_addr_a_i.elem];
      rd_data_q.src2 <= mem_q[rd_addr_b_i.vreg][rd_addr_b_i.elem];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_en_i;
    end
  end

  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

/* lane_sequencer.sv */
// Lane sequencer
// Accepts one instruction, issues one element per cycle, waits for completion

`timescale 1ns/1ps
`default_nettype none

module lane_sequencer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Instruction port
  input  lane_insn_pkg::lane_req_t   req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  // Register file reads
  output logic                       rd_en_o,
  output lane_cfg_pkg::vrf_addr_t    rd_addr_a_o,
  output lane_cfg_pkg::vrf_addr_t    rd_addr_b_o,
  // Command queue push
  output lane_insn_pkg::alu_uop_t    uop_o,
  output logic                       uop_valid_o,
  // Completion from the ALU
  input  logic                       insn_done_i
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT
  } seq_state_e;

  seq_state_e                state_q, state_d;
  lane_insn_pkg::lane_req_t  req_q;
  lane_cfg_pkg::elem_idx_t   cnt_q;
  logic                      accept;
  logic                      last_elem;

  // A new request may be taken in the done cycle of the previous one
  assign req_ready_o = (state_q == SEQ_IDLE) || ((state_q == SEQ_WAIT) && insn_done_i);
  assign accept      = req_valid_i && req_ready_o;

  assign last_elem = (lane_cfg_pkg::vl_t'(cnt_q) == (req_q.vl - lane_cfg_pkg::vl_t'(1)));

  //////////////////////////////////////////////////
  // Element issue
  //////////////////////////////////////////////////

  // Broadcast needs no operands
  assign rd_en_o     = (state_q == SEQ_ISSUE) && (req_q.op != lane_insn_pkg::VMVX);
  assign rd_addr_a_o = '{vreg: req_q.vs1, elem: cnt_q};
  assign rd_addr_b_o = '{vreg: req_q.vs2, elem: cnt_q};

  assign uop_valid_o = (state_q == SEQ_ISSUE);
  assign uop_o       = '{op:     req_q.op,
                         dst:    '{vreg: req_q.vd, elem: cnt_q},
                         last:   last_elem,
                         scalar: req_q.scalar};

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (accept) begin
          state_d = SEQ_ISSUE;
        end
      end
      SEQ_ISSUE: begin
        if (last_elem) begin
          state_d = SEQ_WAIT;
        end
      end
      SEQ_WAIT: begin
        if (accept) begin
          state_d = SEQ_ISSUE;
        end else if (insn_done_i) begin
          state_d = SEQ_IDLE;
        end
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        cnt_q <= '0;
      end else if (state_q == SEQ_ISSUE) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Accepted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

endmodule

`default_nettype wire

/* lane_alu.sv */
// Lane ALU
// Joins the command and operand queue heads, writes back or stores,
// and flags the end of each instruction

`timescale 1ns/1ps
`default_nettype none

module lane_alu (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Command queue head
  input  lane_insn_pkg::alu_uop_t      uop_i,
  input  logic                         uop_valid_i,
  output logic                         uop_pop_o,
  // Operand queue head
  input  lane_cfg_pkg::operand_pair_t  opnd_i,
  input  logic                         opnd_valid_i,
  output logic                         opnd_pop_o,
  // Register file write port
  output logic                         wr_en_o,
  output lane_cfg_pkg::vrf_addr_t      wr_addr_o,
  output lane_cfg_pkg::elem_t          wr_data_o,
  // Store stream
  output lane_insn_pkg::store_beat_t   store_o,
  output logic                         store_valid_o,
  input  logic                         store_ready_i,
  // Completion pulse
  output logic                         insn_done_o
);

  logic                 is_mvx;
  logic                 is_store;
  logic                 opnd_ok;
  logic                 fire;
  lane_cfg_pkg::elem_t  result;
  logic                 done_q;

  assign is_mvx   = (uop_i.op == lane_insn_pkg::VMVX);
  assign is_store = (uop_i.op == lane_insn_pkg::VSTORE);

  // Broadcast does not wait for the operand queue
  assign opnd_ok = is_mvx || opnd_valid_i;
  assign fire    = uop_valid_i && opnd_ok && (!is_store || store_ready_i);

  assign uop_pop_o  = fire;
  assign opnd_pop_o = fire && !is_mvx;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_comb begin
    case (uop_i.op)
      lane_insn_pkg::VADD:   result = opnd_i.src1 + opnd_i.src2;
      lane_insn_pkg::VSUB:   result = opnd_i.src1 - opnd_i.src2;
      lane_insn_pkg::VAND:   result = opnd_i.src1 & opnd_i.src2;
      lane_insn_pkg::VOR:    result = opnd_i.src1 | opnd_i.src2;
      lane_insn_pkg::VXOR:   result = opnd_i.src1 ^ opnd_i.src2;
      lane_insn_pkg::VMVX:   result = uop_i.scalar;
      // Store passes the second source through
      default:               result = opnd_i.src2;
    endcase
  end

  assign wr_en_o   = fire && !is_store;
  assign wr_addr_o = uop_i.dst;
  assign wr_data_o = result;

  // Valid must not depend on ready, so the beat holds under back-pressure
  assign store_valid_o = uop_valid_i && is_store && opnd_valid_i;
  assign store_o       = '{data: result, last: uop_i.last};

  //////////////////////////////////////////////////
  // Completion
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= fire && uop_i.last;
    end
  end

  assign insn_done_o = done_q;

endmodule

`default_nettype wire

/* lane_top.sv */
// Vector lane top level
// Sequencer, register file, operand and command queues, ALU

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module lane_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Instruction port
  input  lane_insn_pkg::lane_req_t    req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  // Store stream
  output lane_insn_pkg::store_beat_t  store_o,
  output logic                        store_valid_o,
  input  logic                        store_ready_i,
  // Completion
  output logic                        insn_done_o
);

  // Sequencer outputs
  logic                         rd_en;
  lane_cfg_pkg::vrf_addr_t      rd_addr_a, rd_addr_b;
  lane_insn_pkg::alu_uop_t      uop_push;
  logic                         uop_push_valid;
  // Register file to operand queue
  lane_cfg_pkg::operand_pair_t  rd_data;
  logic                         rd_valid;
  // Queue heads
  lane_insn_pkg::alu_uop_t      uop_head;
  logic                         uop_head_valid, uop_pop;
  lane_cfg_pkg::operand_pair_t  opnd_head;
  logic                         opnd_head_valid, opnd_pop;
  // Writeback
  logic                         wr_en;
  lane_cfg_pkg::vrf_addr_t      wr_addr;
  lane_cfg_pkg::elem_t          wr_data;

  lane_sequencer i_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rd_en_o     (rd_en),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .uop_o       (uop_push),
    .uop_valid_o (uop_push_valid),
    .insn_done_i (insn_done_o)
  );

  vector_regfile i_vrf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_data_o   (rd_data),
    .rd_valid_o  (rd_valid),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data)
  );

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  stream_fifo #(
    .payload_t (lane_cfg_pkg::operand_pair_t),
    .DEPTH     (`LANE_QUEUE_DEPTH)
  ) i_opnd_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rd_valid),
    .data_i  (rd_data),
    .data_o  (opnd_head),
    .valid_o (opnd_head_valid),
    .pop_i   (opnd_pop)
  );

  stream_fifo #(
    .payload_t (lane_insn_pkg::alu_uop_t),
    .DEPTH     (`LANE_QUEUE_DEPTH)
  ) i_cmd_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (uop_push_valid),
    .data_i  (uop_push),
    .data_o  (uop_head),
    .valid_o (uop_head_valid),
    .pop_i   (uop_pop)
  );

  lane_alu i_alu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .uop_i         (uop_head),
    .uop_valid_i   (uop_head_valid),
    .uop_pop_o     (uop_pop),
    .opnd_i        (opnd_head),
    .opnd_valid_i  (opnd_head_valid),
    .opnd_pop_o    (opnd_pop),
    .wr_en_o       (wr_en),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .store_o       (store_o),
    .store_valid_o (store_valid_o),
    .store_ready_i (store_ready_i),
    .insn_done_o   (insn_done_o)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock and reset generator
// 10 ns clock, active-low reset held for a number of cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned reset_cycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    // Release away from the rising edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* lane_assert.sv */
// Protocol assertions for the lane top level
// Reset values, instruction handshake, completion pulse and latency,
// store stream hold under back-pressure

`timescale 1ns/1ps
`default_nettype none

module lane_assert (
  input logic                        clk_i,
  input logic                        rst_ni,
  input lane_insn_pkg::lane_req_t    req_i,
  input logic                        req_valid_i,
  input logic                        req_ready_o,
  input lane_insn_pkg::store_beat_t  store_o,
  input logic                        store_valid_o,
  input logic                        store_ready_i,
  input logic                        insn_done_o
);

  logic               accept;
  logic               busy_q;
  logic               arith_q;
  lane_cfg_pkg::vl_t  vl_q;
  logic [15:0]        cyc_q;

  // Failure counts, one per assertion
  int unsigned reset_fails   = 0;
  int unsigned ready_fails   = 0;
  int unsigned orphan_fails  = 0;
  int unsigned pulse_fails   = 0;
  int unsigned latency_fails = 0;
  int unsigned hold_fails    = 0;
  int unsigned stray_fails   = 0;
  int unsigned fail_total;

  assign fail_total = reset_fails + ready_fails + orphan_fails + pulse_fails
                    + latency_fails + hold_fails + stray_fails;

  assign accept = req_valid_i && req_ready_o;

  // Outstanding instruction and cycles since its acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      arith_q <= 1'b0;
      vl_q    <= '0;
      cyc_q   <= '0;
    end else if (accept) begin
      busy_q  <= 1'b1;
      arith_q <= req_i.op inside {lane_insn_pkg::VADD, lane_insn_pkg::VSUB,
                                  lane_insn_pkg::VAND, lane_insn_pkg::VOR,
                                  lane_insn_pkg::VXOR};
      vl_q    <= req_i.vl;
      cyc_q   <= '0;
    end else begin
      if (insn_done_o) begin
        busy_q <= 1'b0;
      end
      cyc_q <= cyc_q + 16'd1;
    end
  end

  reset_values: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> req_ready_o && !store_valid_o && !insn_done_o)
    else begin
      $error("Outputs not at their reset values after reset release");
      reset_fails++;
    end

  // Ready low while busy, high again in the done cycle
  ready_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ready_o == (!busy_q || insn_done_o))
    else begin
      $error("req_ready_o does not follow the instruction in flight");
      ready_fails++;
    end

  done_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_done_o |-> busy_q)
    else begin
      $error("insn_done_o without an accepted instruction");
      orphan_fails++;
    end

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_done_o |=> !insn_done_o)
    else begin
      $error("insn_done_o longer than one cycle");
      pulse_fails++;
    end

  arith_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_done_o && arith_q |-> cyc_q == 16'(vl_q) + 16'd2)
    else begin
      $error("Arithmetic done after %0d cycles, vl %0d", cyc_q, vl_q);
      latency_fails++;
    end

  store_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_valid_o && !store_ready_i |=> store_valid_o && $stable(store_o))
    else begin
      $error("Store beat changed or dropped under back-pressure");
      hold_fails++;
    end

  store_in_insn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_valid_o |-> busy_q)
    else begin
      $error("Store beat outside an instruction");
      stray_fails++;
    end

endmodule

bind lane_top lane_assert i_assert (.*);

`default_nettype wire

/* lane_tb.sv */
// Testbench for the vector lane
// Stimulus, shadow register model, store beat checks, watchdog, summary

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module lane_tb;

  localparam int unsigned num_arith = 20;
  localparam int unsigned num_bp    = 6;
  localparam int unsigned num_done  = 8;
  // Broadcast plus store per register, arithmetic plus store, the rest single
  localparam int unsigned num_insns = 2 * `LANE_NR_VREGS + 2 * num_arith + num_bp + num_done;
  localparam int unsigned watchdog_cycles = num_insns * (`LANE_VLMAX + 2) * 20 + 500;

  logic                        clk;
  logic                        rst_n;
  lane_insn_pkg::lane_req_t    req;
  logic                        req_valid;
  logic                        req_ready;
  lane_insn_pkg::store_beat_t  store_beat;
  logic                        store_valid;
  logic                        store_ready;
  logic                        insn_done;

  lane_cfg_pkg::elem_t model [`LANE_NR_VREGS][`LANE_VLMAX];

  int seed = 39397;
  int errs;
  int err_mark;
  int accepted;
  int dones = 0;
  int tests_passed;
  int tests_failed;

  tb_clk_gen #(.reset_cycles(4)) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lane_top uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (req),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .store_o       (store_beat),
    .store_valid_o (store_valid),
    .store_ready_i (store_ready),
    .insn_done_o   (insn_done)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Element rule of each opcode
  function automatic lane_cfg_pkg::elem_t apply_op(input lane_insn_pkg::opcode_e op,
                                                   input lane_cfg_pkg::elem_t a,
                                                   input lane_cfg_pkg::elem_t b,
                                                   input lane_cfg_pkg::elem_t s);
    case (op)
      lane_insn_pkg::VADD: return a + b;
      lane_insn_pkg::VSUB: return a - b;
      lane_insn_pkg::VAND: return a & b;
      lane_insn_pkg::VOR:  return a | b;
      lane_insn_pkg::VXOR: return a ^ b;
      lane_insn_pkg::VMVX: return s;
      default:             return b;
    endcase
  endfunction

  function automatic lane_insn_pkg::lane_req_t make_req(input lane_insn_pkg::opcode_e op,
                                                        input int unsigned vd,
                                                        input int unsigned vs1,
                                                        input int unsigned vs2,
                                                        input int unsigned vl,
                                                        input lane_cfg_pkg::elem_t scalar);
    lane_insn_pkg::lane_req_t r;
    r.op     = op;
    r.vd     = lane_cfg_pkg::vreg_idx_t'(vd);
    r.vs1    = lane_cfg_pkg::vreg_idx_t'(vs1);
    r.vs2    = lane_cfg_pkg::vreg_idx_t'(vs2);
    r.vl     = lane_cfg_pkg::vl_t'(vl);
    r.scalar = scalar;
    return r;
  endfunction

  function automatic int total_errors();
    return errs + int'(uut.i_assert.fail_total);
  endfunction

  task automatic mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errs++;
  endtask

  task automatic end_test(input string name);
    int n;
    repeat (2) @(posedge clk);
    n = total_errors() - err_mark;
    if (n == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %-14s %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
    err_mark = total_errors();
  endtask

  // Completion pulses seen on the DUT output
  always @(negedge clk) begin
    if (rst_n && insn_done) begin
      dones++;
    end
  end

  //////////////////////////////////////////////////
  // Instruction and store handling
  //////////////////////////////////////////////////

  // Called at a rising edge, returns at the edge of acceptance
  task automatic send_req(input lane_insn_pkg::lane_req_t r);
    req       <= r;
    req_valid <= 1'b1;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    accepted++;
  endtask

  task automatic check_beat(input lane_insn_pkg::lane_req_t r, input int beat);
    lane_cfg_pkg::elem_t expected;
    if (beat >= int'(r.vl)) begin
      $display("Extra store beat %0d beyond vector length %0d at %0t", beat, r.vl, $time);
      errs++;
    end else begin
      expected = model[r.vs2][beat];
      assert (store_beat.data == expected)
        else mismatch($sformatf("v%0d[%0d] stored 0x%08h, expected 0x%08h",
                                r.vs2, beat, store_beat.data, expected));
      assert (store_beat.last == (beat == int'(r.vl) - 1))
        else mismatch($sformatf("last flag %0b on beat %0d of %0d",
                                store_beat.last, beat, r.vl));
    end
  endtask

  task automatic run_insn(input lane_insn_pkg::lane_req_t r, input bit back_pressure);
    int beat;
    bit seen_done;
    beat      = 0;
    seen_done = 1'b0;
    send_req(r);
    while (!seen_done) begin
      if (back_pressure) begin
        store_ready <= 1'($random(seed));
      end
      // Handshake signals are settled by the falling edge
      @(negedge clk);
      if (store_valid && store_ready) begin
        check_beat(r, beat);
        beat++;
      end
      if (insn_done) begin
        seen_done = 1'b1;
      end
      @(posedge clk);
    end
    store_ready <= 1'b1;
    if (r.op == lane_insn_pkg::VSTORE) begin
      assert (beat == int'(r.vl))
        else begin
          $display("Store of v%0d delivered %0d of %0d beats", r.vs2, beat, r.vl);
          errs++;
        end
    end else begin
      for (int e = 0; e < int'(r.vl); e++) begin
        model[r.vd][e] = apply_op(r.op, model[r.vs1][e], model[r.vs2][e], r.scalar);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    lane_insn_pkg::opcode_e op;
    int unsigned            vd;
    int unsigned            vs1;
    int unsigned            vs2;
    req          = '0;
    req_valid    = 1'b0;
    store_ready  = 1'b1;
    errs         = 0;
    err_mark     = 0;
    accepted     = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int r = 0; r < `LANE_NR_VREGS; r++) begin
      for (int e = 0; e < `LANE_VLMAX; e++) begin
        model[r][e] = '0;
      end
    end

    @(posedge rst_n);
    @(posedge clk);
    end_test("reset");

    // Scalar into every register, then read each one back in full
    for (int v = 0; v < `LANE_NR_VREGS; v++) begin
      run_insn(make_req(lane_insn_pkg::VMVX, v, 0, 0, rnd(`LANE_VLMAX) + 1,
                        lane_cfg_pkg::elem_t'($random(seed))), 1'b0);
    end
    for (int v = 0; v < `LANE_NR_VREGS; v++) begin
      run_insn(make_req(lane_insn_pkg::VSTORE, 0, 0, v, `LANE_VLMAX, '0), 1'b0);
    end
    end_test("broadcast_store");

    for (int i = 0; i < num_arith; i++) begin
      op  = lane_insn_pkg::opcode_e'(rnd(5));
      vd  = rnd(`LANE_NR_VREGS);
      vs1 = rnd(`LANE_NR_VREGS);
      // Every fourth one writes over its own source
      vs2 = (i % 4 == 0) ? vd : rnd(`LANE_NR_VREGS);
      run_insn(make_req(op, vd, vs1, vs2, rnd(`LANE_VLMAX) + 1, '0), 1'b0);
      run_insn(make_req(lane_insn_pkg::VSTORE, 0, 0, vd, `LANE_VLMAX, '0), 1'b0);
    end
    end_test("arithmetic");

    for (int i = 0; i < num_bp; i++) begin
      run_insn(make_req(lane_insn_pkg::VSTORE, 0, 0, rnd(`LANE_NR_VREGS),
                        rnd(`LANE_VLMAX) + 1, '0), 1'b1);
    end
    end_test("back_pressure");

    // Every length once for the latency check
    for (int i = 0; i < num_done; i++) begin
      op = (i % 3 == 0) ? lane_insn_pkg::VMVX : lane_insn_pkg::opcode_e'(rnd(5));
      run_insn(make_req(op, rnd(`LANE_NR_VREGS), rnd(`LANE_NR_VREGS), rnd(`LANE_NR_VREGS),
                        (i % `LANE_VLMAX) + 1, lane_cfg_pkg::elem_t'($random(seed))), 1'b0);
    end
    assert (dones == accepted)
      else begin
        $display("Saw %0d completions for %0d accepted instructions", dones, accepted);
        errs++;
      end
    end_test("completion");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the instruction count
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
lane_cfg_pkg.sv
lane_insn_pkg.sv
stream_fifo.sv
vector_regfile.sv
lane_sequencer.sv
lane_alu.sv
lane_top.sv
tb_clk_gen.sv
lane_assert.sv
lane_tb.sv

/* Makefile */
# Verilator build and run of the vector lane testbench

VERILATOR ?= verilator
TOP       ?= lane_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and fail if the testbench reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "Result: no verdict"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
